/* octet_core.f */
+incdir+test
source/octet_pkg.sv
source/octet_regfile.sv
source/octet_alu.sv
source/octet_branch.sv
source/octet_sequencer.sv
source/octet_core.sv
test/octet_core_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the octet_core testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 \
    --top-module octet_core_tb \
    -f octet_core.f \
    -o octet_core_sim
./obj_dir/octet_core_sim

/* source/octet_alu.sv */
`timescale 1ns/1ps

module octet_alu
(
    input  octet_pkg::instr_t   instr,
    input  logic [31:0]         read_a,
    input  logic [31:0]         read_b,
    output octet_pkg::alu_out_t result
);

    import octet_pkg::*;

    logic [32:0] sum;
    logic [32:0] diff;
    logic [31:0] logic_value;
    logic [31:0] imm_value;

    // extra bit holds carry out and borrow
    assign sum  = {1'b0, read_a} + {1'b0, read_b};
    assign diff = {1'b0, read_a} - {1'b0, read_b};

    always_comb
    begin
        case (instr.opcode)
            OP_AND:  logic_value = read_a & read_b;
            OP_OR:   logic_value = read_a | read_b;
            default: logic_value = read_a ^ read_b;
        endcase
    end

    // high select keeps the lower half of source A
    assign imm_value = instr.high ? {instr.imm, read_a[15:0]} : {16'h0000, instr.imm};

    always_comb
    begin
        result.result    = '0;
        result.flag      = 1'b0;
        result.write_reg = 1'b0;
        case (instr.opcode)
            OP_ADD:
            begin
                result.result    = sum[31:0];
                result.flag      = sum[32];
                result.write_reg = 1'b1;
            end
            OP_SUB:
            begin
                result.result    = diff[31:0];
                result.flag      = diff[32];
                result.write_reg = 1'b1;
            end
            OP_AND, OP_OR, OP_XOR:
            begin
                result.result    = logic_value;
                result.flag      = (logic_value == '0);
                result.write_reg = 1'b1;
            end
            OP_LDI:
            begin
                result.result    = imm_value;
                result.write_reg = 1'b1;
            end
            OP_CMPEQ:
            begin
                result.result    = diff[31:0];
                result.flag      = (read_a == read_b);
                result.write_reg = 1'b1;
            end
            default:
            begin
                // store, jumps, halt and nop leave the registers alone
                result.write_reg = 1'b0;
            end
        endcase
    end

endmodule

/* source/octet_branch.sv */
`timescale 1ns/1ps

module octet_branch
#(
    parameter int ADDR_WIDTH = 10
)
(
    input  octet_pkg::instr_t      instr,
    input  logic [ADDR_WIDTH-1:0]  pc,
    input  logic                   flag_a,
    output octet_pkg::branch_out_t next
);

    import octet_pkg::*;

    logic [ADDR_WIDTH-1:0] pc_inc;
    logic [ADDR_WIDTH-1:0] jump_addr;
    logic                  redirect;

    assign pc_inc    = pc + 1'b1;
    assign jump_addr = instr.imm[ADDR_WIDTH-1:0];

    always_comb
    begin
        case (instr.opcode)
            OP_JMP:  redirect = 1'b1;
            // conditional on the flag paired with source A
            OP_JMPF: redirect = flag_a;
            default: redirect = 1'b0;
        endcase
    end

    // target is zero extended to the full 16 bit field
    always_comb
    begin
        next.taken  = redirect;
        next.target = '0;
        if (redirect)
        begin
            next.target[ADDR_WIDTH-1:0] = jump_addr;
        end
        else
        begin
            next.target[ADDR_WIDTH-1:0] = pc_inc;
        end
    end

endmodule

/* source/octet_core.sv */
`timescale 1ns/1ps

module octet_core
#(
    parameter int ADDR_WIDTH = 10
)
(
    input  logic                  clock,
    input  logic                  rst_n,
    input  logic [31:0]           mem_rdata,
    output logic [ADDR_WIDTH-1:0] mem_addr,
    output logic [31:0]           mem_wdata,
    output logic                  mem_write,
    output logic                  halted
);

    import octet_pkg::*;

    instr_t                instr;
    logic [ADDR_WIDTH-1:0] pc;
    logic [31:0]           read_a;
    logic [31:0]           read_b;
    logic                  flag_a;
    alu_out_t              alu_result;
    branch_out_t           branch_next;
    logic                  write_en;
    logic                  write_flag;
    reg_index_t            write_index;
    logic [31:0]           write_data;

    octet_regfile regfile_i
    (
        .clock       (clock),
        .rst_n       (rst_n),
        .index_a     (instr.src_a),
        .index_b     (instr.src_b),
        .write_index (write_index),
        .write_en    (write_en),
        .write_flag  (write_flag),
        .write_data  (write_data),
        .read_a      (read_a),
        .read_b      (read_b),
        .flag_a      (flag_a)
    );

    octet_alu alu_i
    (
        .instr  (instr),
        .read_a (read_a),
        .read_b (read_b),
        .result (alu_result)
    );

    octet_branch #(.ADDR_WIDTH(ADDR_WIDTH)) branch_i
    (
        .instr  (instr),
        .pc     (pc),
        .flag_a (flag_a),
        .next   (branch_next)
    );

    octet_sequencer #(.ADDR_WIDTH(ADDR_WIDTH)) sequencer_i
    (
        .clock       (clock),
        .rst_n       (rst_n),
        .mem_rdata   (mem_rdata),
        .alu         (alu_result),
        .branch      (branch_next),
        .instr       (instr),
        .pc          (pc),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .read_a      (read_a),
        .mem_write   (mem_write),
        .write_en    (write_en),
        .write_flag  (write_flag),
        .halted      (halted),
        .write_index (write_index),
        .write_data  (write_data)
    );

endmodule

/* source/octet_pkg.sv */
package octet_pkg;

    // unknown operation codes decode as OP_NOP
    typedef enum logic [5:0] {
        OP_NOP   = 6'd0,
        OP_ADD   = 6'd1,
        OP_SUB   = 6'd2,
        OP_AND   = 6'd3,
        OP_OR    = 6'd4,
        OP_XOR   = 6'd5,
        OP_LDI   = 6'd6,
        OP_STORE = 6'd7,
        OP_CMPEQ = 6'd8,
        OP_JMP   = 6'd9,
        OP_JMPF  = 6'd10,
        OP_HALT  = 6'd11
    } opcode_e;

    typedef enum logic [1:0] {
        ST_FETCH   = 2'd0,
        ST_EXECUTE = 2'd1,
        ST_ADVANCE = 2'd2,
        ST_HALTED  = 2'd3
    } state_e;

    typedef logic [2:0] reg_index_t;

    // instruction word laid out msb first
    typedef struct packed {
        logic [15:0] imm;
        logic        high;
        reg_index_t  dest;
        reg_index_t  src_b;
        reg_index_t  src_a;
        opcode_e     opcode;
    } instr_t;

    typedef struct packed {
        logic [31:0] result;
        logic        flag;
        // destination register and flag are written
        logic        write_reg;
    } alu_out_t;

    typedef struct packed {
        logic [15:0] target;
        logic        taken;
    } branch_out_t;

endpackage

/* source/octet_regfile.sv */
`timescale 1ns/1ps

module octet_regfile
(
    input  logic                  clock,
    input  logic                  rst_n,
    input  octet_pkg::reg_index_t index_a,
    input  octet_pkg::reg_index_t index_b,
    input  octet_pkg::reg_index_t write_index,
    input  logic                  write_en,
    input  logic                  write_flag,
    input  logic [31:0]           write_data,
    output logic [31:0]           read_a,
    output logic [31:0]           read_b,
    output logic                  flag_a
);

    logic [31:0] regs [8];
    logic [7:0]  flags;

    // register and flag are always written as a pair
    always_ff @(posedge clock or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < 8; i++)
            begin
                regs[i] <= '0;
            end
            flags <= '0;
        end
        else if (write_en)
        begin
            regs[write_index]  <= write_data;
            flags[write_index] <= write_flag;
        end
    end

    // combinational reads with no bypass from the write port
    assign read_a = regs[index_a];
    assign read_b = regs[index_b];
    assign flag_a = flags[index_a];

endmodule

/* source/octet_sequencer.sv */
`timescale 1ns/1ps

module octet_sequencer
#(
    parameter int ADDR_WIDTH = 10
)
(
    input  logic                   clock,
    input  logic                   rst_n,
    input  logic [31:0]            mem_rdata,
    input  octet_pkg::alu_out_t    alu,
    input  octet_pkg::branch_out_t branch,
    output octet_pkg::instr_t      instr,
    output logic [ADDR_WIDTH-1:0]  pc,
    output logic [ADDR_WIDTH-1:0]  mem_addr,
    output logic [31:0]            mem_wdata,
    input  logic [31:0]            read_a,
    output logic                   mem_write,
    output logic                   write_en,
    output logic                   write_flag,
    output logic                   halted,
    output octet_pkg::reg_index_t  write_index,
    output logic [31:0]            write_data
);

    import octet_pkg::*;

    state_e state;
    state_e state_next;
    logic   executing;
    logic   is_store;

    assign executing = (state == ST_EXECUTE);
    assign is_store  = (instr.opcode == OP_STORE);

    always_comb
    begin
        case (state)
            ST_FETCH:   state_next = ST_EXECUTE;
            ST_EXECUTE: state_next = (instr.opcode == OP_HALT) ? ST_HALTED : ST_ADVANCE;
            ST_ADVANCE: state_next = ST_FETCH;
            default:    state_next = ST_HALTED;
        endcase
    end

    always_ff @(posedge clock or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state <= ST_FETCH;
            pc    <= '0;
            instr <= '0;
        end
        else
        begin
            state <= state_next;
            if (state == ST_FETCH)
            begin
                instr <= instr_t'(mem_rdata);
            end
            if (state == ST_ADVANCE)
            begin
                pc <= branch.taken ? branch.target[ADDR_WIDTH-1:0] : pc + 1'b1;
            end
        end
    end

    // store address replaces pc only during its execute cycle
    assign mem_addr  = (executing && is_store) ? instr.imm[ADDR_WIDTH-1:0] : pc;
    assign mem_wdata = read_a;
    assign mem_write = executing && is_store;

    assign write_en    = executing && alu.write_reg;
    assign write_index = instr.dest;
    assign write_data  = alu.result;
    assign write_flag  = alu.flag;

    assign halted = (state == ST_HALTED);

endmodule

/* test/octet_core_prog.svh */
`ifndef OCTET_CORE_PROG_SVH
`define OCTET_CORE_PROG_SVH

// fibonacci lfsr with taps 32 22 2 1 and one step per bit taken
function automatic logic [31:0] rand_bits(input int count);
    logic [31:0] value;
    logic        fb;
    value = '0;
    for (int i = 0; i < count; i++)
    begin
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        value = {value[30:0], fb};
    end
    return value;
endfunction

function automatic logic [31:0] encode(input logic [5:0] op, input int d, input int a,
                                       input int b, input logic high, input logic [15:0] imm);
    return {imm, high, 3'(d), 3'(b), 3'(a), op};
endfunction

task automatic emit(input logic [5:0] op, input int d, input int a, input int b,
                    input logic high, input logic [15:0] imm);
    prog_words.push_back(encode(op, d, a, b, high, imm));
endtask

// full 32 bit load in two halves
task automatic load_reg(input int d, input logic [31:0] value);
    emit(6'd6, d, 0, 0, 1'b0, value[15:0]);
    emit(6'd6, d, d, 0, 1'b1, value[31:16]);
endtask

// independent model of the instruction rules
task automatic interpret();
    logic [31:0] r [8];
    logic [7:0]  fl;
    logic [31:0] w;
    logic [31:0] a;
    logic [31:0] b;
    logic [32:0] wide;
    logic [5:0]  op;
    int          d;
    int          pc;
    int          next_pc;
    bit          done;
    for (int i = 0; i < 8; i++)
    begin
        r[i] = '0;
    end
    fl = '0;
    pc = 0;
    done = 0;
    exp_pc.delete();
    exp_is_store.delete();
    exp_addr.delete();
    exp_data.delete();
    exp_count = 0;
    while (!done)
    begin
        w = (pc < prog_words.size()) ? prog_words[pc] : fill_word(pc);
        op = w[5:0];
        a = r[w[8:6]];
        b = r[w[11:9]];
        d = int'(w[14:12]);
        next_pc = (pc + 1) % MEM_WORDS;
        exp_pc.push_back(pc);
        exp_is_store.push_back(op == 6'd7);
        exp_count++;
        case (op)
            6'd1:
            begin
                wide = {1'b0, a} + {1'b0, b};
                r[d] = wide[31:0];
                fl[d] = wide[32];
            end
            6'd2:
            begin
                wide = {1'b0, a} - {1'b0, b};
                r[d] = wide[31:0];
                fl[d] = wide[32];
            end
            6'd3, 6'd4, 6'd5:
            begin
                r[d] = (op == 6'd3) ? (a & b) : ((op == 6'd4) ? (a | b) : (a ^ b));
                fl[d] = (r[d] == 0);
            end
            6'd6:
            begin
                r[d] = w[15] ? {w[31:16], a[15:0]} : {16'h0000, w[31:16]};
                fl[d] = 1'b0;
            end
            6'd7:
            begin
                exp_addr.push_back(int'(w[31:16]) % MEM_WORDS);
                exp_data.push_back(a);
            end
            6'd8:
            begin
                r[d] = a - b;
                fl[d] = (a == b);
            end
            6'd9: next_pc = int'(w[31:16]) % MEM_WORDS;
            6'd10:
            begin
                if (fl[w[8:6]])
                begin
                    next_pc = int'(w[31:16]) % MEM_WORDS;
                end
            end
            6'd11: done = 1;
            default: ;
        endcase
        pc = next_pc;
        if (exp_count > 2000)
        begin
            report_failure("reference model ran away without a halt");
        end
    end
endtask

`endif

/* test/octet_core_tb.sv */
`timescale 1ns/1ps

module octet_core_tb;

    localparam int ADDR_WIDTH = 10;
    localparam int MEM_WORDS  = 1 << ADDR_WIDTH;
    localparam int SKIP_ADDR  = 500;

    logic                  clock;
    logic                  rst_n;
    logic [31:0]           mem_rdata;
    logic [ADDR_WIDTH-1:0] mem_addr;
    logic [31:0]           mem_wdata;
    logic                  mem_write;
    logic                  halted;

    logic [31:0] mem [MEM_WORDS];
    logic [31:0] image [MEM_WORDS];
    logic [31:0] lfsr_state;
    logic [31:0] prog_words [$];
    int          exp_pc [$];
    bit          exp_is_store [$];
    int          exp_addr [$];
    logic [31:0] exp_data [$];
    int          exp_count;
    string       test_name;
    int          cycle;
    bit          halt_seen;
    longint      budget_ns;

    task automatic report_mismatch(input string what, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("[ERROR] %s: %s expected %h actual %h", test_name, what, expected, actual);
        $display("tests failed");
        $fatal(1, "mismatch in %s", test_name);
    endtask

    task automatic report_failure(input string what);
        $display("%s: %s", test_name, what);
        $display("tests failed");
        $fatal(1, "failure in %s", test_name);
    endtask

    // unused words decode as nop with a pattern that follows the address
    function automatic logic [31:0] fill_word(input int addr);
        return {addr[15:0], 16'h0040};
    endfunction

    `include "octet_core_prog.svh"

    octet_core #(.ADDR_WIDTH(ADDR_WIDTH)) octet_core_i
    (
        .clock     (clock),
        .rst_n     (rst_n),
        .mem_rdata (mem_rdata),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_write (mem_write),
        .halted    (halted)
    );

    initial
    begin
        clock = 1'b0;
        forever
        begin
            #10 clock = ~clock;
        end
    end

    assign mem_rdata = mem[mem_addr];

    // memory model and cycle checks where cycle 1 is the first after reset
    always @(posedge clock)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < MEM_WORDS; i++)
            begin
                mem[i] <= image[i];
            end
            cycle = 0;
            halt_seen = 0;
        end
        else
        begin
            cycle = cycle + 1;
            if (cycle == 1)
            begin
                assert (mem_addr == 0) else report_mismatch("reset mem_addr", 0, 32'(mem_addr));
                assert (!mem_write) else report_mismatch("reset mem_write", 0, 32'(mem_write));
                assert (!halted) else report_mismatch("reset halted", 0, 32'(halted));
            end
            if (halt_seen)
            begin
                assert (halted) else report_failure("halted dropped after halt");
                assert (!mem_write) else report_failure("store strobe while halted");
            end
            else if (halted)
            begin
                assert (cycle == 3 * exp_count)
                    else report_mismatch("halt cycle", 32'(3 * exp_count), 32'(cycle));
                halt_seen = 1;
            end
            else
            begin
                assert (cycle < 3 * exp_count) else report_failure("core did not halt in time");
                case ((cycle - 1) % 3)
                    0:
                    begin
                        assert (int'(mem_addr) == exp_pc[(cycle - 1) / 3])
                            else report_mismatch("fetch address",
                                                 32'(exp_pc[(cycle - 1) / 3]), 32'(mem_addr));
                        assert (!mem_write) else report_failure("store strobe in fetch");
                    end
                    1:
                    begin
                        assert (mem_write == exp_is_store[(cycle - 1) / 3])
                            else report_mismatch("store strobe",
                                                 32'(exp_is_store[(cycle - 1) / 3]),
                                                 32'(mem_write));
                    end
                    default:
                    begin
                        assert (!mem_write) else report_failure("store strobe in advance");
                    end
                endcase
                if (mem_write)
                begin
                    assert (exp_addr.size() > 0) else report_failure("unexpected store");
                    assert (int'(mem_addr) != SKIP_ADDR)
                        else report_failure("store inside skipped block");
                    assert (int'(mem_addr) == exp_addr[0])
                        else report_mismatch("store address", 32'(exp_addr[0]), 32'(mem_addr));
                    assert (mem_wdata == exp_data[0])
                        else report_mismatch("store data", exp_data[0], mem_wdata);
                    void'(exp_addr.pop_front());
                    void'(exp_data.pop_front());
                    mem[mem_addr] <= mem_wdata;
                end
            end
        end
    end

    task automatic build_program(input int which);
        logic [5:0] ops [6];
        logic [5:0] cond_op [8];
        int         cond_a [8];
        int         cond_b [8];
        int         p;
        ops = '{6'd1, 6'd2, 6'd3, 6'd4, 6'd5, 6'd8};
        cond_op = '{6'd1, 6'd1, 6'd2, 6'd2, 6'd3, 6'd5, 6'd8, 6'd8};
        cond_a = '{1, 6, 0, 1, 1, 1, 1, 1};
        cond_b = '{2, 7, 1, 1, 0, 2, 1, 2};
        prog_words.delete();
        case (which)
            0:
            begin
                load_reg(1, rand_bits(32));
                load_reg(2, rand_bits(32));
                for (int k = 0; k < 6; k++)
                begin
                    emit(ops[k], 3, 1, 2, 1'b0, 16'h0);
                    emit(6'd7, 0, 3, 0, 1'b0, 16'(200 + k));
                end
                emit(6'd8, 5, 1, 1, 1'b0, 16'h0);
                emit(6'd7, 0, 5, 0, 1'b0, 16'd210);
            end
            1:
            begin
                load_reg(1, rand_bits(32));
                load_reg(2, rand_bits(32));
                load_reg(6, 32'hffff_ffff);
                load_reg(7, 32'h0000_0001);
                // flag set skips the first store of each pair
                for (int k = 0; k < 8; k++)
                begin
                    emit(cond_op[k], 3, cond_a[k], cond_b[k], 1'b0, 16'h0);
                    p = prog_words.size();
                    emit(6'd10, 0, 3, 0, 1'b0, 16'(p + 2));
                    emit(6'd7, 0, 3, 0, 1'b0, 16'(300 + 2 * k));
                    emit(6'd7, 0, 1, 0, 1'b0, 16'(301 + 2 * k));
                end
            end
            default:
            begin
                load_reg(1, rand_bits(32));
                p = prog_words.size();
                emit(6'd9, 0, 0, 0, 1'b0, 16'(p + 3));
                emit(6'd7, 0, 1, 0, 1'b0, 16'(SKIP_ADDR));
                emit(6'd11, 0, 0, 0, 1'b0, 16'h0);
                emit(6'd7, 0, 1, 0, 1'b0, 16'(SKIP_ADDR + 1));
            end
        endcase
        emit(6'd11, 0, 0, 0, 1'b0, 16'h0);
    endtask

    task automatic run_program(input int which, input string name);
        @(posedge clock);
        #1;
        rst_n = 1'b0;
        test_name = name;
        build_program(which);
        interpret();
        for (int i = 0; i < MEM_WORDS; i++)
        begin
            image[i] = (i < prog_words.size()) ? prog_words[i] : fill_word(i);
        end
        repeat (3) @(posedge clock);
        #1;
        rst_n = 1'b1;
        while (!halt_seen)
        begin
            @(posedge clock);
        end
        repeat (4) @(posedge clock);
        assert (exp_addr.size() == 0) else report_failure("expected stores never happened");
    endtask

    // watchdog budget comes from the reference instruction counts
    initial
    begin
        wait (budget_ns > 0);
        #(budget_ns);
        $display("timeout after %0d ns", budget_ns);
        $display("tests failed");
        $fatal(1, "watchdog expired");
    end

    initial
    begin
        rst_n = 1'b0;
        budget_ns = 0;
        lfsr_state = 32'hd5ab_2b0d;
        for (int t = 0; t < 3; t++)
        begin
            build_program(t);
            interpret();
            budget_ns += longint'(3 * exp_count + 20) * 20;
        end
        lfsr_state = 32'hd5ab_2b0d;
        run_program(0, "arith_logic");
        run_program(1, "flag_branch");
        run_program(2, "uncond_jump");
        $display("all tests passed");
        $finish;
    end

endmodule
